// File: csr_unit.f
+incdir+logic
logic/csr_pkg.sv
logic/csr_request_decode.sv
logic/csr_trap_ctrl.sv
logic/csr_file.sv
logic/csr_response_buffer.sv
logic/csr_unit.sv
testbench/csr_unit_tb.sv

// File: testbench/csr_unit_input.txt
// cmd addr wdata pc exc_valid exc_cause | rdata trap cause redirect target
// All fields hex; commands 1=W 2=S 3=C 4=ECALL 5=MRET 6=SRET
2 300 00000000 00000100 0 00000000 00001800 0 00000000 0 00000000
2 301 00000000 00000104 0 00000000 40001101 0 00000000 0 00000000
2 7c0 00000000 00000108 0 00000000 00000000 0 00000000 0 00000000
1 340 12345678 0000010c 0 00000000 00000000 0 00000000 0 00000000
2 340 0000f0f0 00000110 0 00000000 12345678 0 00000000 0 00000000
3 340 12340000 00000114 0 00000000 1234f6f8 0 00000000 0 00000000
1 340 00000000 00000118 0 00000000 0000f6f8 0 00000000 0 00000000
2 302 00000104 0000011c 0 00000000 00000000 0 00000000 0 00000000
3 302 00000004 00000120 0 00000000 00000104 0 00000000 0 00000000
1 302 00000100 00000124 0 00000000 00000100 0 00000000 0 00000000
1 341 00000207 00000128 0 00000000 00000000 0 00000000 0 00000000
2 341 00000000 0000012c 0 00000000 00000204 0 00000000 0 00000000
1 c00 deadbeef 00000130 0 00000000 00000000 0 00000000 0 00000000
2 c00 00000000 00000134 0 00000000 00000000 0 00000000 0 00000000
1 305 00000801 00000138 0 00000000 00000000 0 00000000 0 00000000
4 000 00000000 00001000 0 00000000 00000000 1 0000000b 1 00000800
2 342 00000000 00000800 0 00000000 0000000b 0 00000000 0 00000000
1 341 00002000 00000804 0 00000000 00001000 0 00000000 0 00000000
3 300 00001800 00000808 0 00000000 00001800 0 00000000 0 00000000
5 000 00000000 0000080c 0 00000000 00000000 0 00000000 1 00002000
5 000 00000000 00002000 0 00000000 00000000 1 00000002 1 00000800
1 105 00000403 00000800 0 00000000 00000000 0 00000000 0 00000000
1 341 00003000 00000804 0 00000000 00002000 0 00000000 0 00000000
5 000 00000000 00000808 0 00000000 00000000 0 00000000 1 00003000
4 000 00000000 00003010 0 00000000 00000000 1 00000008 1 00000400
2 142 00000000 00000400 0 00000000 00000008 0 00000000 0 00000000
1 340 00000055 00004000 0 00000000 00000000 1 00000002 1 00000800
5 000 00000000 00000800 0 00000000 00000000 0 00000000 1 00004000
5 000 00000000 00004004 0 00000000 00000000 1 00000002 1 00000800
2 300 00400000 00000800 0 00000000 00000800 0 00000000 0 00000000
5 000 00000000 00000804 0 00000000 00000000 0 00000000 1 00004004
6 000 00000000 00004008 0 00000000 00000000 1 00000002 1 00000800
6 000 00000000 00000800 0 00000000 00000000 0 00000000 1 00003010
4 000 00000000 00003020 1 00000005 00000000 1 00000005 1 00000800
2 342 00000000 00000800 0 00000000 00000005 0 00000000 0 00000000

// File: testbench/csr_unit_tb.sv
`timescale 1ns/1ps
`include "csr_config.svh"

module csr_unit_tb
    import csr_pkg::*;
();

    localparam int FIELDS = 11;

    logic     clk;
    logic     rst_i;
    logic     req_valid;
    logic     req_ready;
    csr_req_t req;
    logic     rsp_valid;
    logic     rsp_ready;
    csr_rsp_t rsp;

    csr_req_t    req_vec [$];
    csr_rsp_t    exp_vec [$];
    csr_rsp_t    exp_q [$];
    int          num_txn;
    int          rsp_count;
    int          check_count;
    int          error_count;
    int          cycle_count;
    int          cycle_limit;

    csr_unit u_csr_unit (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_valid_i (req_valid),
        .req_ready_o (req_ready),
        .req_i       (req),
        .rsp_valid_o (rsp_valid),
        .rsp_ready_i (rsp_ready),
        .rsp_o       (rsp)
    );

    always #10 clk = ~clk;

    // Each line holds the request fields followed by the expected response
    task automatic load_vectors();
        int       fd;
        int       cnt;
        string    line;
        xlen_t    f [FIELDS];
        csr_req_t r;
        csr_rsp_t e;
        fd = $fopen("testbench/csr_unit_input.txt", "r");
        assert (fd != 0) else begin
            error_count++;
            $display("ERROR: could not open the stimulus file");
        end
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                cnt = $fgets(line, fd);
                if (cnt > 1 && line.substr(0, 1) != "//") begin
                    cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
                                  f[0], f[1], f[2], f[3], f[4], f[5],
                                  f[6], f[7], f[8], f[9], f[10]);
                    if (cnt == FIELDS) begin
                        r.cmd       = f[0][`CSR_CMD_BITS-1:0];
                        r.addr      = f[1][`CSR_ADDR_W-1:0];
                        r.wdata     = f[2];
                        r.pc        = f[3];
                        r.exc_valid = f[4][0];
                        r.exc_cause = f[5];
                        e.rdata     = f[6];
                        e.trap      = f[7][0];
                        e.cause     = f[8];
                        e.redirect  = f[9][0];
                        e.target    = f[10];
                        req_vec.push_back(r);
                        exp_vec.push_back(e);
                    end
                end
            end
            $fclose(fd);
        end
        num_txn = req_vec.size();
        assert (num_txn > 0) else begin
            error_count++;
            $display("ERROR: no transactions were read from the stimulus file");
        end
    endtask

    task automatic check_field(input string name, input xlen_t got, input xlen_t exp,
                               input int idx);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("FAIL %s: got 0x%08h, expected 0x%08h (transaction %0d)",
                     name, got, exp, idx);
        end
    endtask

    task automatic check_response();
        csr_rsp_t exp;
        check_count++;
        assert (exp_q.size() > 0) else begin
            error_count++;
            $display("ERROR: a response arrived with no request outstanding");
        end
        if (exp_q.size() > 0) begin
            exp = exp_q.pop_front();
            check_field("rsp_o.rdata", rsp.rdata, exp.rdata, rsp_count);
            check_field("rsp_o.trap", xlen_t'(rsp.trap), xlen_t'(exp.trap), rsp_count);
            check_field("rsp_o.cause", rsp.cause, exp.cause, rsp_count);
            check_field("rsp_o.redirect", xlen_t'(rsp.redirect), xlen_t'(exp.redirect),
                        rsp_count);
            check_field("rsp_o.target", rsp.target, exp.target, rsp_count);
        end
        rsp_count++;
    endtask

    // Random idle gaps between requests
    task automatic drive_requests();
        int idx;
        int gap;
        for (idx = 0; idx < num_txn; idx++) begin
            gap = $urandom_range(2, 0);
            req_valid = 1'b0;
            repeat (gap) @(negedge clk);
            req = req_vec[idx];
            req_valid = 1'b1;
            @(posedge clk);
            while (!req_ready) begin
                @(posedge clk);
            end
            exp_q.push_back(exp_vec[idx]);
            @(negedge clk);
        end
        req_valid = 1'b0;
    endtask

    task automatic report_counts();
        $display("Checks: %0d, errors: %0d, responses: %0d of %0d",
                 check_count, error_count, rsp_count, num_txn);
    endtask

    // Output side stalls about a quarter of the time
    always @(negedge clk) begin
        if (rst_i) begin
            rsp_ready = 1'b0;
        end else begin
            rsp_ready = ($urandom_range(3, 0) != 0);
        end
    end

    always @(posedge clk) begin
        if (!rst_i && rsp_valid && rsp_ready) begin
            check_response();
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles with responses still missing", cycle_count);
            report_counts();
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        clk = 1'b0;
        rst_i = 1'b1;
        req_valid = 1'b0;
        req = '0;
        rsp_ready = 1'b0;
        rsp_count = 0;
        check_count = 0;
        error_count = 0;
        cycle_count = 0;
        void'($urandom(32'hc89d5239));
        load_vectors();
        cycle_limit = num_txn * 20 + 200;

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;

        check_count++;
        assert (!rsp_valid && req_ready) else begin
            error_count++;
            $display("ERROR: after reset a response is pending or requests are refused");
        end

        drive_requests();
        wait (rsp_count >= num_txn);

        // Any late extra response is caught by the checker
        repeat (8) @(negedge clk);
        check_count++;
        assert (!rsp_valid && exp_q.size() == 0) else begin
            error_count++;
            $display("ERROR: responses left over at the end of the run");
        end

        report_counts();
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: logic/csr_unit.sv
`timescale 1ns/1ps

module csr_unit
    import csr_pkg::*;
(
    input  logic     clk,
    input  logic     rst_i,
    input  logic     req_valid_i,
    output logic     req_ready_o,
    input  csr_req_t req_i,
    output logic     rsp_valid_o,
    input  logic     rsp_ready_i,
    output csr_rsp_t rsp_o
);

    logic        dec_valid;
    csr_dec_t    dec;
    logic        buf_ready;
    logic        fire;
    csr_state_t  state;
    csr_action_t action;
    xlen_t       rdata;
    csr_rsp_t    rsp_in;

    // Decode stage advances into the response buffer
    assign fire = dec_valid && buf_ready;

    csr_request_decode u_decode (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_i       (req_i),
        .fire_i      (fire),
        .dec_valid_o (dec_valid),
        .dec_o       (dec)
    );

    csr_trap_ctrl u_trap_ctrl (
        .dec_i      (dec),
        .state_i    (state),
        .action_o   (action),
        .trap_o     (rsp_in.trap),
        .cause_o    (rsp_in.cause),
        .redirect_o (rsp_in.redirect),
        .target_o   (rsp_in.target)
    );

    csr_file u_file (
        .clk      (clk),
        .rst_i    (rst_i),
        .fire_i   (fire),
        .dec_i    (dec),
        .action_i (action),
        .state_o  (state),
        .rdata_o  (rdata)
    );

    assign rsp_in.rdata = rdata;

    csr_response_buffer u_rsp_buffer (
        .clk         (clk),
        .rst_i       (rst_i),
        .in_valid_i  (dec_valid),
        .in_ready_o  (buf_ready),
        .in_i        (rsp_in),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_o       (rsp_o)
    );

endmodule

// File: logic/csr_response_buffer.sv
`timescale 1ns/1ps

module csr_response_buffer
    import csr_pkg::*;
(
    input  logic     clk,
    input  logic     rst_i,
    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  csr_rsp_t in_i,
    output logic     rsp_valid_o,
    input  logic     rsp_ready_i,
    output csr_rsp_t rsp_o
);

    logic load;

    // Empty, or the held response is taken this cycle
    assign in_ready_o = !rsp_valid_o || rsp_ready_i;
    assign load       = in_valid_i && in_ready_o;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            rsp_valid_o <= 1'b0;
        end else if (load) begin
            rsp_valid_o <= 1'b1;
        end else if (rsp_ready_i) begin
            rsp_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            rsp_o <= in_i;
        end
    end

    assert property (@(posedge clk) disable iff (rst_i)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o));

endmodule

// File: logic/csr_file.sv
`timescale 1ns/1ps
`include "csr_config.svh"

module csr_file
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        rst_i,
    input  logic        fire_i,
    input  csr_dec_t    dec_i,
    input  csr_action_t action_i,
    output csr_state_t  state_o,
    output xlen_t       rdata_o
);

    localparam xlen_t MSTATUS_RST = `CSR_MSTATUS_RESET;

    priv_t mode;
    logic  mie;
    logic  sie;
    logic  mpie;
    logic  spie;
    priv_t mpp;
    logic  spp;
    logic  tsr;
    xlen_t medeleg;
    xlen_t mtvec;
    xlen_t stvec;
    xlen_t mscratch;
    xlen_t sscratch;
    xlen_t mepc;
    xlen_t sepc;
    xlen_t mcause;
    xlen_t scause;

    xlen_t mstatus;
    xlen_t sstatus;
    xlen_t old_value;
    xlen_t wdata;
    logic  write_en;
    logic  trap;

    assign mstatus = {9'b0, tsr, 9'b0, mpp, 2'b0, spp, mpie, 1'b0, spie, 1'b0,
                      mie, 1'b0, sie, 1'b0};
    // S-level view of the same bits
    assign sstatus = {23'b0, spp, 2'b0, spie, 3'b0, sie, 1'b0};

    always_comb begin
        case (dec_i.addr)
            `CSR_ADDR_MSTATUS:  old_value = mstatus;
            `CSR_ADDR_SSTATUS:  old_value = sstatus;
            `CSR_ADDR_MISA:     old_value = `CSR_MISA_VALUE;
            `CSR_ADDR_MEDELEG:  old_value = medeleg;
            `CSR_ADDR_MTVEC:    old_value = mtvec;
            `CSR_ADDR_STVEC:    old_value = stvec;
            `CSR_ADDR_MSCRATCH: old_value = mscratch;
            `CSR_ADDR_SSCRATCH: old_value = sscratch;
            `CSR_ADDR_MEPC:     old_value = mepc;
            `CSR_ADDR_SEPC:     old_value = sepc;
            `CSR_ADDR_MCAUSE:   old_value = mcause;
            `CSR_ADDR_SCAUSE:   old_value = scause;
            default:            old_value = '0;
        endcase
    end

    // Read-modify-write
    always_comb begin
        case (action_i.cmd)
            `CSR_CMD_W: wdata = action_i.wdata_operand;
            `CSR_CMD_S: wdata = old_value | action_i.wdata_operand;
            `CSR_CMD_C: wdata = old_value & ~action_i.wdata_operand;
            default:    wdata = old_value;
        endcase
    end

    assign trap     = action_i.trap_to_m || action_i.trap_to_s;
    assign write_en = action_i.do_write && !dec_i.addr_readonly && dec_i.addr_known;
    assign rdata_o  = (dec_i.is_write && !trap) ? old_value : '0;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            mode     <= `CSR_PRIV_M;
            tsr      <= MSTATUS_RST[22];
            mpp      <= MSTATUS_RST[12:11];
            spp      <= MSTATUS_RST[8];
            mpie     <= MSTATUS_RST[7];
            spie     <= MSTATUS_RST[5];
            mie      <= MSTATUS_RST[3];
            sie      <= MSTATUS_RST[1];
            medeleg  <= '0;
            mtvec    <= '0;
            stvec    <= '0;
            mscratch <= '0;
            sscratch <= '0;
            mepc     <= '0;
            sepc     <= '0;
            mcause   <= '0;
            scause   <= '0;
        end else if (fire_i) begin
            if (action_i.trap_to_m) begin
                mode   <= `CSR_PRIV_M;
                mcause <= action_i.cause;
                mepc   <= {action_i.epc[`CSR_XLEN-1:2], 2'b00};
                mpie   <= mie;
                mie    <= 1'b0;
                mpp    <= mode;
            end else if (action_i.trap_to_s) begin
                mode   <= `CSR_PRIV_S;
                scause <= action_i.cause;
                sepc   <= action_i.epc;
                spie   <= sie;
                sie    <= 1'b0;
                spp    <= mode[0];
            end else if (action_i.do_mret) begin
                mie  <= mpie;
                mode <= mpp;
                mpie <= 1'b1;
                mpp  <= `CSR_PRIV_U;
            end else if (action_i.do_sret) begin
                sie  <= spie;
                mode <= {1'b0, spp};
                spie <= 1'b1;
                spp  <= 1'b0;
            end else if (write_en) begin
                case (action_i.addr)
                    `CSR_ADDR_MSTATUS: begin
                        tsr  <= wdata[22];
                        // Reserved mode 2 reads back as U
                        mpp  <= (wdata[12:11] == 2'b10) ? `CSR_PRIV_U : wdata[12:11];
                        spp  <= wdata[8];
                        mpie <= wdata[7];
                        spie <= wdata[5];
                        mie  <= wdata[3];
                        sie  <= wdata[1];
                    end
                    `CSR_ADDR_SSTATUS: begin
                        spp  <= wdata[8];
                        spie <= wdata[5];
                        sie  <= wdata[1];
                    end
                    `CSR_ADDR_MEDELEG:  medeleg  <= wdata;
                    `CSR_ADDR_MTVEC:    mtvec    <= wdata;
                    `CSR_ADDR_STVEC:    stvec    <= wdata;
                    `CSR_ADDR_MSCRATCH: mscratch <= wdata;
                    `CSR_ADDR_SSCRATCH: sscratch <= wdata;
                    `CSR_ADDR_MEPC:     mepc     <= {wdata[`CSR_XLEN-1:2], 2'b00};
                    `CSR_ADDR_SEPC:     sepc     <= wdata;
                    `CSR_ADDR_MCAUSE:   mcause   <= wdata;
                    `CSR_ADDR_SCAUSE:   scause   <= wdata;
                    default: begin
                    end
                endcase
            end
        end
    end

    always_comb begin
        state_o.mode    = mode;
        state_o.mie     = mie;
        state_o.sie     = sie;
        state_o.mpie    = mpie;
        state_o.spie    = spie;
        state_o.mpp     = mpp;
        state_o.spp     = spp;
        state_o.tsr     = tsr;
        state_o.medeleg = medeleg;
        state_o.mtvec   = mtvec;
        state_o.stvec   = stvec;
        state_o.mepc    = mepc;
        state_o.sepc    = sepc;
    end

    // Traps, returns and mstatus writes never reach the reserved mode
    assert property (@(posedge clk) disable iff (rst_i) mode != 2'b10);

endmodule

// File: logic/csr_trap_ctrl.sv
`timescale 1ns/1ps
`include "csr_config.svh"

module csr_trap_ctrl
    import csr_pkg::*;
(
    input  csr_dec_t    dec_i,
    input  csr_state_t  state_i,
    output csr_action_t action_o,
    output logic        trap_o,
    output xlen_t       cause_o,
    output logic        redirect_o,
    output xlen_t       target_o
);

    logic  access_fault;
    logic  xret_illegal;
    logic  raise;
    logic  to_s;
    xlen_t cause;
    xlen_t mtvec_base;
    xlen_t stvec_base;

    // Write to a CSR owned by a more privileged mode
    assign access_fault = dec_i.is_write && (dec_i.addr_priv > state_i.mode);

    assign xret_illegal =
        ((dec_i.cmd == `CSR_CMD_MRET) && (state_i.mode != `CSR_PRIV_M)) ||
        ((dec_i.cmd == `CSR_CMD_SRET) && (state_i.mode == `CSR_PRIV_U)) ||
        ((dec_i.cmd == `CSR_CMD_SRET) && (state_i.mode == `CSR_PRIV_S) && state_i.tsr);

    assign raise = dec_i.exc_valid || dec_i.is_ecall || access_fault || xret_illegal;

    // Earlier stage exception wins over ECALL, ECALL over illegal
    always_comb begin
        if (dec_i.exc_valid) begin
            cause = dec_i.exc_cause;
        end else if (dec_i.is_ecall) begin
            cause = xlen_t'(`CSR_CAUSE_ECALL_U) + xlen_t'(state_i.mode);
        end else begin
            cause = xlen_t'(`CSR_CAUSE_ILLEGAL);
        end
    end

    // M-mode traps are never delegated
    assign to_s = (state_i.mode != `CSR_PRIV_M) && state_i.medeleg[cause[4:0]];

    // Only exceptions exist, so vectored mode resolves to the base too
    assign mtvec_base = {state_i.mtvec[`CSR_XLEN-1:2], 2'b00};
    assign stvec_base = {state_i.stvec[`CSR_XLEN-1:2], 2'b00};

    always_comb begin
        action_o.do_write      = dec_i.is_write && !raise;
        action_o.trap_to_m     = raise && !to_s;
        action_o.trap_to_s     = raise && to_s;
        action_o.do_mret       = (dec_i.cmd == `CSR_CMD_MRET) && !raise;
        action_o.do_sret       = (dec_i.cmd == `CSR_CMD_SRET) && !raise;
        action_o.cause         = cause;
        action_o.epc           = dec_i.pc;
        action_o.addr          = dec_i.addr;
        action_o.wdata_operand = dec_i.wdata;
        action_o.cmd           = dec_i.cmd;
    end

    assign trap_o     = raise;
    assign cause_o    = raise ? cause : '0;
    // Every trap and every return redirects
    assign redirect_o = raise || dec_i.is_xret;

    always_comb begin
        if (action_o.trap_to_m) begin
            target_o = mtvec_base;
        end else if (action_o.trap_to_s) begin
            target_o = stvec_base;
        end else if (action_o.do_mret) begin
            target_o = state_i.mepc;
        end else if (action_o.do_sret) begin
            target_o = state_i.sepc;
        end else begin
            target_o = '0;
        end
    end

    // At most one of trap, return or write reaches the register file
    always_comb begin
        assert final ($onehot0({action_o.trap_to_m, action_o.trap_to_s,
                                action_o.do_mret, action_o.do_sret,
                                action_o.do_write}));
    end

endmodule

// File: logic/csr_request_decode.sv
`timescale 1ns/1ps
`include "csr_config.svh"

module csr_request_decode
    import csr_pkg::*;
(
    input  logic     clk,
    input  logic     rst_i,
    input  logic     req_valid_i,
    output logic     req_ready_o,
    input  csr_req_t req_i,
    input  logic     fire_i,
    output logic     dec_valid_o,
    output csr_dec_t dec_o
);

    csr_dec_t dec_next;
    logic     accept;

    // Free slot, or the held entry leaves this cycle
    assign req_ready_o = !dec_valid_o || fire_i;
    assign accept      = req_valid_i && req_ready_o;

    always_comb begin
        dec_next.cmd       = req_i.cmd;
        dec_next.addr      = req_i.addr;
        dec_next.wdata     = req_i.wdata;
        dec_next.pc        = req_i.pc;
        dec_next.exc_valid = req_i.exc_valid;
        dec_next.exc_cause = req_i.exc_cause;

        dec_next.is_write  = (req_i.cmd == `CSR_CMD_W) ||
                             (req_i.cmd == `CSR_CMD_S) ||
                             (req_i.cmd == `CSR_CMD_C);
        dec_next.is_xret   = (req_i.cmd == `CSR_CMD_MRET) ||
                             (req_i.cmd == `CSR_CMD_SRET);
        dec_next.is_ecall  = (req_i.cmd == `CSR_CMD_ECALL);

        // Address map fields
        dec_next.addr_priv     = req_i.addr[9:8];
        dec_next.addr_readonly = (req_i.addr[11:10] == 2'b11);

        case (req_i.addr)
            `CSR_ADDR_SSTATUS, `CSR_ADDR_STVEC, `CSR_ADDR_SSCRATCH,
            `CSR_ADDR_SEPC, `CSR_ADDR_SCAUSE, `CSR_ADDR_MSTATUS,
            `CSR_ADDR_MISA, `CSR_ADDR_MEDELEG, `CSR_ADDR_MTVEC,
            `CSR_ADDR_MSCRATCH, `CSR_ADDR_MEPC, `CSR_ADDR_MCAUSE: begin
                dec_next.addr_known = 1'b1;
            end
            default: begin
                dec_next.addr_known = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            dec_valid_o <= 1'b0;
        end else if (accept) begin
            dec_valid_o <= 1'b1;
        end else if (fire_i) begin
            dec_valid_o <= 1'b0;
        end
    end

    // Request and its classification
    always_ff @(posedge clk) begin
        if (accept) begin
            dec_o <= dec_next;
        end
    end

    // Held entry must not change while the output side stalls
    assert property (@(posedge clk) disable iff (rst_i)
        dec_valid_o && !fire_i |=> dec_valid_o && $stable(dec_o));

endmodule

// File: logic/csr_pkg.sv
`include "csr_config.svh"

package csr_pkg;

    typedef logic [`CSR_XLEN-1:0]      xlen_t;
    typedef logic [`CSR_ADDR_W-1:0]    csr_addr_t;
    typedef logic [`CSR_CMD_BITS-1:0]  csr_cmd_t;
    typedef logic [`CSR_PRIV_BITS-1:0] priv_t;

    // One instruction's CSR request
    typedef struct packed {
        csr_cmd_t  cmd;
        csr_addr_t addr;
        xlen_t     wdata;
        xlen_t     pc;
        logic      exc_valid;
        xlen_t     exc_cause;
    } csr_req_t;

    // Request plus state-free classification
    typedef struct packed {
        csr_cmd_t  cmd;
        csr_addr_t addr;
        xlen_t     wdata;
        xlen_t     pc;
        logic      exc_valid;
        xlen_t     exc_cause;
        logic      is_write;
        logic      is_xret;
        logic      is_ecall;
        priv_t     addr_priv;
        logic      addr_readonly;
        logic      addr_known;
    } csr_dec_t;

    // Snapshot used by the trap decision
    typedef struct packed {
        priv_t mode;
        logic  mie;
        logic  sie;
        logic  mpie;
        logic  spie;
        priv_t mpp;
        logic  spp;
        logic  tsr;
        xlen_t medeleg;
        xlen_t mtvec;
        xlen_t stvec;
        xlen_t mepc;
        xlen_t sepc;
    } csr_state_t;

    typedef struct packed {
        logic      do_write;
        logic      trap_to_m;
        logic      trap_to_s;
        logic      do_mret;
        logic      do_sret;
        xlen_t     cause;
        xlen_t     epc;
        csr_addr_t addr;
        xlen_t     wdata_operand;
        csr_cmd_t  cmd;
    } csr_action_t;

    typedef struct packed {
        xlen_t rdata;
        logic  trap;
        xlen_t cause;
        logic  redirect;
        xlen_t target;
    } csr_rsp_t;

endpackage

// File: logic/csr_config.svh
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// Widths
`define CSR_XLEN          32
`define CSR_ADDR_W        12
`define CSR_CMD_BITS      3
`define CSR_PRIV_BITS     2

// Command codes
`define CSR_CMD_NONE      3'd0
`define CSR_CMD_W         3'd1
`define CSR_CMD_S         3'd2
`define CSR_CMD_C         3'd3
`define CSR_CMD_ECALL     3'd4
`define CSR_CMD_MRET      3'd5
`define CSR_CMD_SRET      3'd6

// Privilege modes with code 2 reserved
`define CSR_PRIV_U        2'd0
`define CSR_PRIV_S        2'd1
`define CSR_PRIV_M        2'd3

// Kept CSR addresses
`define CSR_ADDR_SSTATUS  12'h100
`define CSR_ADDR_STVEC    12'h105
`define CSR_ADDR_SSCRATCH 12'h140
`define CSR_ADDR_SEPC     12'h141
`define CSR_ADDR_SCAUSE   12'h142
`define CSR_ADDR_MSTATUS  12'h300
`define CSR_ADDR_MISA     12'h301
`define CSR_ADDR_MEDELEG  12'h302
`define CSR_ADDR_MTVEC    12'h305
`define CSR_ADDR_MSCRATCH 12'h340
`define CSR_ADDR_MEPC     12'h341
`define CSR_ADDR_MCAUSE   12'h342

// Exception causes
`define CSR_CAUSE_ILLEGAL 32'd2
`define CSR_CAUSE_ECALL_U 32'd8

// MXL of 32 with the I, M and A extensions
`define CSR_MISA_VALUE    32'h4000_1101
`define CSR_MSTATUS_RESET 32'h0000_1800

`endif
